// ==== arch_state.f ====
hw/arch_state_pkg.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/commit_ctrl.sv
hw/arch_state_top.sv
verification/tb_clock_gen.sv
verification/arch_state_tb.sv

// ==== hw/arch_state_pkg.sv ====
package arch_state_pkg;

  // ====================
  // basic types
  // ====================

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    csr_op_none  = 2'd0,
    csr_op_write = 2'd1,
    csr_op_set   = 2'd2,
    csr_op_clear = 2'd3
  } csr_op_e;

  // machine-mode CSR addresses.
  localparam csr_addr_t csr_mstatus   = 12'h300;
  localparam csr_addr_t csr_mtvec     = 12'h305;
  localparam csr_addr_t csr_mepc      = 12'h341;
  localparam csr_addr_t csr_mcause    = 12'h342;
  localparam csr_addr_t csr_mvendorid = 12'hF11;
  localparam csr_addr_t csr_marchid   = 12'hF12;

  // exception codes written into mcause.
  localparam xlen_t cause_ecall_m         = 32'd11;
  localparam xlen_t cause_inst_misaligned = 32'd0;

  // mstatus comes up with MPP set to machine mode.
  localparam xlen_t mstatus_reset   = 32'h0000_1800;
  localparam xlen_t mvendorid_value = 32'h7973_7978;
  localparam xlen_t marchid_value   = 32'h017D_9F58;

  // ====================
  // bundles
  // ====================

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     next_pc;
    logic [4:0] rd;
    logic      wen;
    xlen_t     wdata;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    xlen_t     csr_operand;
    logic      ecall;
    logic      misaligned;
    logic      fence_i;
    logic      mispredict;
  } retire_t;

  typedef struct packed {
    logic  flush;
    logic  flush_cache;
    xlen_t npc;
  } redirect_t;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    xlen_t     operand;
    logic      trap;
    xlen_t     cause;
    xlen_t     epc;
  } csr_cmd_t;

endpackage

// ==== hw/arch_state_top.sv ====
`timescale 1ns/10ps

module arch_state_top
  import arch_state_pkg::*;
#(
  parameter int num_gprs = 16
) (
  input  logic       clock,
  input  logic       reset,

  input  retire_t    retire_in,

  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  input  csr_addr_t  csr_raddr,
  output xlen_t      src1,
  output xlen_t      src2,
  output xlen_t      csr_rdata,

  output redirect_t  redirect
);

  logic       gpr_wen;
  logic [4:0] gpr_waddr;
  xlen_t      gpr_wdata;
  csr_cmd_t   csr_cmd;
  xlen_t      mtvec_value;

  commit_ctrl u_commit_ctrl (
    .clock       (clock),
    .reset       (reset),
    .retire_in   (retire_in),
    .mtvec_value (mtvec_value),
    .gpr_wen     (gpr_wen),
    .gpr_waddr   (gpr_waddr),
    .gpr_wdata   (gpr_wdata),
    .csr_cmd     (csr_cmd),
    .redirect    (redirect)
  );

  gpr_file #(
    .num_gprs (num_gprs)
  ) u_gpr_file (
    .clock     (clock),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .src1      (src1),
    .src2      (src2),
    .gpr_wen   (gpr_wen),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata)
  );

  csr_file u_csr_file (
    .clock       (clock),
    .reset       (reset),
    .csr_cmd     (csr_cmd),
    .csr_raddr   (csr_raddr),
    .csr_rdata   (csr_rdata),
    .mtvec_value (mtvec_value)
  );

endmodule

// ==== hw/commit_ctrl.sv ====
`timescale 1ns/10ps

module commit_ctrl
  import arch_state_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  retire_t    retire_in,
  input  xlen_t      mtvec_value,

  output logic       gpr_wen,
  output logic [4:0] gpr_waddr,
  output xlen_t      gpr_wdata,

  output csr_cmd_t   csr_cmd,

  output redirect_t  redirect
);

  logic      squash;
  logic      take;
  logic      trap;
  logic      commit_ok;
  xlen_t     trap_cause;
  redirect_t redirect_next;

  // ====================
  // packet qualification
  // ====================

  // the packet arriving while flush is high is on the wrong path.
  assign squash = redirect.flush;
  assign take   = retire_in.valid && !squash;

  assign trap      = take && (retire_in.ecall || retire_in.misaligned);
  assign commit_ok = take && !trap;

  // ecall wins when both exception flags are set.
  assign trap_cause = retire_in.ecall ? cause_ecall_m : cause_inst_misaligned;

  // ====================
  // write commands
  // ====================

  assign gpr_wen   = commit_ok && retire_in.wen;
  assign gpr_waddr = retire_in.rd;
  assign gpr_wdata = retire_in.wdata;

  always_comb begin
    csr_cmd         = '0;
    csr_cmd.op      = commit_ok ? retire_in.csr_op : csr_op_none;
    csr_cmd.addr    = retire_in.csr_addr;
    csr_cmd.operand = retire_in.csr_operand;
    csr_cmd.trap    = trap;
    csr_cmd.cause   = trap_cause;
    csr_cmd.epc     = retire_in.pc;
  end

  // ====================
  // redirect
  // ====================

  // without a valid packet the fetch PC holds its last value.
  always_comb begin
    redirect_next.flush       = 1'b0;
    redirect_next.flush_cache = 1'b0;
    redirect_next.npc         = redirect.npc;
    if (trap) begin
      redirect_next.flush = 1'b1;
      redirect_next.npc   = mtvec_value;
    end else if (commit_ok) begin
      redirect_next.npc = retire_in.next_pc;
      if (retire_in.fence_i) begin
        redirect_next.flush       = 1'b1;
        redirect_next.flush_cache = 1'b1;
      end else if (retire_in.mispredict) begin
        redirect_next.flush = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      redirect <= '0;
    end else begin
      redirect <= redirect_next;
    end
  end

  // a flush squashes the next packet, so it can never repeat back to back.
  flush_is_pulse: assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush |=> !redirect.flush
  );

  // an instruction cache flush only happens together with a pipeline flush.
  cache_flush_with_flush: assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush_cache |-> redirect.flush
  );

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/10ps

module csr_file
  import arch_state_pkg::*;
(
  input  logic      clock,
  input  logic      reset,

  input  csr_cmd_t  csr_cmd,

  input  csr_addr_t csr_raddr,
  output xlen_t     csr_rdata,

  output xlen_t     mtvec_value
);

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;

  logic wr_mstatus;
  logic wr_mtvec;
  logic wr_mepc;

  // ====================
  // update path
  // ====================

  function automatic xlen_t csr_apply(
    input xlen_t   old_value,
    input csr_op_e op,
    input xlen_t   operand
  );
    xlen_t result;
    unique case (op)
      csr_op_write: result = operand;
      csr_op_set:   result = old_value | operand;
      csr_op_clear: result = old_value & ~operand;
      default:      result = old_value;
    endcase
    return result;
  endfunction

  // mcause only changes on a trap and the identification words are read only.
  assign wr_mstatus = (csr_cmd.op != csr_op_none) && (csr_cmd.addr == csr_mstatus);
  assign wr_mtvec   = (csr_cmd.op != csr_op_none) && (csr_cmd.addr == csr_mtvec);
  assign wr_mepc    = (csr_cmd.op != csr_op_none) && (csr_cmd.addr == csr_mepc);

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (csr_cmd.trap) begin
      mepc   <= csr_cmd.epc;
      mcause <= csr_cmd.cause;
    end else begin
      if (wr_mstatus) begin
        mstatus <= csr_apply(mstatus, csr_cmd.op, csr_cmd.operand);
      end
      if (wr_mtvec) begin
        mtvec <= csr_apply(mtvec, csr_cmd.op, csr_cmd.operand);
      end
      if (wr_mepc) begin
        mepc <= csr_apply(mepc, csr_cmd.op, csr_cmd.operand);
      end
    end
  end

  // ====================
  // read path
  // ====================

  always_comb begin
    unique case (csr_raddr)
      csr_mstatus:   csr_rdata = mstatus;
      csr_mtvec:     csr_rdata = mtvec;
      csr_mepc:      csr_rdata = mepc;
      csr_mcause:    csr_rdata = mcause;
      csr_mvendorid: csr_rdata = mvendorid_value;
      csr_marchid:   csr_rdata = marchid_value;
      default:       csr_rdata = '0;
    endcase
  end

  assign mtvec_value = mtvec;

  // the commit stage must drop the CSR operation of a trapping instruction.
  trap_without_op: assert property (
    @(posedge clock) disable iff (reset)
    csr_cmd.trap |-> (csr_cmd.op == csr_op_none)
  );

endmodule

// ==== hw/gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file
  import arch_state_pkg::*;
#(
  parameter int num_gprs = 16
) (
  input  logic       clock,
  input  logic       reset,

  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  output xlen_t      src1,
  output xlen_t      src2,

  input  logic       gpr_wen,
  input  logic [4:0] gpr_waddr,
  input  xlen_t      gpr_wdata
);

  // only the low address bits select a register, so RV32E ignores bit 4.
  localparam int idx_w = $clog2(num_gprs);

  xlen_t regs [num_gprs];

  logic [idx_w-1:0] rs1_idx;
  logic [idx_w-1:0] rs2_idx;
  logic [idx_w-1:0] waddr_idx;

  assign rs1_idx   = rs1[idx_w-1:0];
  assign rs2_idx   = rs2[idx_w-1:0];
  assign waddr_idx = gpr_waddr[idx_w-1:0];

  assign src1 = regs[rs1_idx];
  assign src2 = regs[rs2_idx];

  // x0 is cleared at reset and never written, so it always reads zero.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_gprs; i++) begin
        regs[i] <= '0;
      end
    end else if (gpr_wen && (waddr_idx != '0)) begin
      regs[waddr_idx] <= gpr_wdata;
    end
  end

  // decode must never retire a register the configured file does not have.
  waddr_in_range: assert property (
    @(posedge clock) disable iff (reset)
    gpr_wen |-> (int'(gpr_waddr) < num_gprs)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module arch_state_tb -f arch_state.f || exit 1
result=$(./obj_dir/Varch_state_tb)
echo "$result"
echo "$result" | grep -qF '*** TEST PASSED ***' && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verification/arch_state_tb.sv ====
`timescale 1ns/10ps

module arch_state_tb
  import arch_state_pkg::*;
();

  localparam int num_gprs  = 16;
  localparam int n_gpr_wr  = 40;
  localparam int n_csr_ops = 24;
  localparam int n_flow    = 30;
  // every step below costs one packet, idle read cycles included.
  localparam int total_packets = 8 + n_gpr_wr + 2 + num_gprs + 2 * n_csr_ops
                               + 9 + 6 + n_flow + 1;
  localparam int cycle_limit   = 2 * total_packets + 50;

  logic       clock;
  logic       reset;
  retire_t    retire_in;
  logic [4:0] rs1;
  logic [4:0] rs2;
  csr_addr_t  csr_raddr;
  xlen_t      src1;
  xlen_t      src2;
  xlen_t      csr_rdata;
  redirect_t  redirect;

  int   seed        = 57;
  int   cycle_count = 0;
  int   check_count = 0;
  int   error_count = 0;
  int   test_errors = 0;
  logic check_en    = 1'b0;

  // reference model of the architectural state.
  xlen_t     ref_regs [num_gprs] = '{default: '0};
  xlen_t     ref_mstatus = 32'h0000_1800;
  xlen_t     ref_mtvec   = '0;
  xlen_t     ref_mepc    = '0;
  xlen_t     ref_mcause  = '0;
  redirect_t exp_next    = '0;
  redirect_t exp_now     = '0;

  tb_clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  arch_state_top #(
    .num_gprs (num_gprs)
  ) u_dut (
    .clock     (clock),
    .reset     (reset),
    .retire_in (retire_in),
    .rs1       (rs1),
    .rs2       (rs2),
    .csr_raddr (csr_raddr),
    .src1      (src1),
    .src2      (src2),
    .csr_rdata (csr_rdata),
    .redirect  (redirect)
  );

  // ====================
  // reference model
  // ====================

  function automatic xlen_t rand_word();
    return $random(seed);
  endfunction

  function automatic retire_t base_packet(input xlen_t pc);
    retire_t p;
    p = '0;
    p.valid   = 1'b1;
    p.pc      = pc;
    p.next_pc = pc + 32'd4;
    return p;
  endfunction

  // a packet that must be dropped because it follows a flush.
  function automatic retire_t wrong_path_packet();
    retire_t p;
    p = base_packet(32'h0000_5000);
    p.wen         = 1'b1;
    p.rd          = 5'd9;
    p.wdata       = rand_word();
    p.csr_op      = csr_op_write;
    p.csr_addr    = csr_mepc;
    p.csr_operand = rand_word();
    return p;
  endfunction

  function automatic redirect_t make_redirect(input logic f, input logic fc, input xlen_t npc);
    redirect_t r;
    r.flush       = f;
    r.flush_cache = fc;
    r.npc         = npc;
    return r;
  endfunction

  function automatic csr_addr_t pick_csr(input logic [2:0] sel);
    csr_addr_t list [8];
    list = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, csr_mvendorid, csr_marchid,
             12'h7C0, 12'h340};
    return list[sel];
  endfunction

  function automatic xlen_t ref_gpr(input logic [4:0] idx);
    int i;
    i = int'(idx) % num_gprs;
    return (i == 0) ? '0 : ref_regs[i];
  endfunction

  function automatic xlen_t ref_csr(input csr_addr_t addr);
    xlen_t v;
    case (addr)
      csr_mstatus:   v = ref_mstatus;
      csr_mtvec:     v = ref_mtvec;
      csr_mepc:      v = ref_mepc;
      csr_mcause:    v = ref_mcause;
      csr_mvendorid: v = mvendorid_value;
      csr_marchid:   v = marchid_value;
      default:       v = '0;
    endcase
    return v;
  endfunction

  function automatic redirect_t ref_redirect(input retire_t pkt, input redirect_t last,
                                             input xlen_t mtvec);
    redirect_t r;
    r = make_redirect(1'b0, 1'b0, last.npc);
    if (pkt.valid && !last.flush) begin
      if (pkt.ecall || pkt.misaligned) begin
        r = make_redirect(1'b1, 1'b0, mtvec);
      end else begin
        r = make_redirect(pkt.fence_i || pkt.mispredict, pkt.fence_i, pkt.next_pc);
      end
    end
    return r;
  endfunction

  task automatic model_step(input retire_t pkt);
    redirect_t nxt;
    logic      taken;
    int        idx;
    xlen_t     old_value;
    xlen_t     new_value;
    nxt   = ref_redirect(pkt, exp_next, ref_mtvec);
    taken = pkt.valid && !exp_next.flush;
    idx   = int'(pkt.rd) % num_gprs;
    if (taken && (pkt.ecall || pkt.misaligned)) begin
      ref_mepc   = pkt.pc;
      ref_mcause = pkt.ecall ? 32'd11 : 32'd0;
    end else if (taken) begin
      if (pkt.wen && (idx != 0)) begin
        ref_regs[idx] = pkt.wdata;
      end
      old_value = ref_csr(pkt.csr_addr);
      case (pkt.csr_op)
        csr_op_write: new_value = pkt.csr_operand;
        csr_op_set:   new_value = old_value | pkt.csr_operand;
        csr_op_clear: new_value = old_value & ~pkt.csr_operand;
        default:      new_value = old_value;
      endcase
      if (pkt.csr_addr == csr_mstatus) ref_mstatus = new_value;
      if (pkt.csr_addr == csr_mtvec)   ref_mtvec   = new_value;
      if (pkt.csr_addr == csr_mepc)    ref_mepc    = new_value;
    end
    exp_next = nxt;
  endtask

  // ====================
  // checks and drivers
  // ====================

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_redirect(input redirect_t got, input redirect_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("ERR %0t: %s flush %b cache %b npc %h, expected %b %b %h", $time, what,
               got.flush, got.flush_cache, got.npc, exp.flush, exp.flush_cache, exp.npc);
    end
  endtask

  task automatic report_test(input string name);
    $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  task automatic drive_cycle(input retire_t pkt);
    @(posedge clock);
    #1;
    retire_in = pkt;
    model_step(pkt);
  endtask

  task automatic read_state(input logic [4:0] a, input logic [4:0] b, input csr_addr_t c);
    drive_cycle('0);
    rs1       = a;
    rs2       = b;
    csr_raddr = c;
    #1;
    check_word(src1, ref_gpr(a), $sformatf("x%0d on port 1", a));
    check_word(src2, ref_gpr(b), $sformatf("x%0d on port 2", b));
    check_word(csr_rdata, ref_csr(c), $sformatf("csr %h", c));
  endtask

  always @(posedge clock) exp_now <= exp_next;

  always @(negedge clock) begin
    if (check_en) begin
      check_redirect(redirect, exp_now, "cycle redirect");
    end
  end

  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ====================
  // tests
  // ====================

  initial begin
    retire_t   pkt;
    xlen_t     r;
    xlen_t     pc;
    xlen_t     prev_npc;
    csr_addr_t addr;
    retire_in = '0;
    rs1       = '0;
    rs2       = '0;
    csr_raddr = '0;
    prev_npc  = '0;
    wait (reset == 1'b0);
    check_en = 1'b1;

    for (int i = 0; i < 8; i++) begin
      read_state(5'(2 * i), 5'(2 * i + 1), pick_csr(3'(i)));
    end
    check_redirect(redirect, make_redirect(1'b0, 1'b0, '0), "reset redirect");
    report_test("reset state");

    for (int i = 0; i < n_gpr_wr; i++) begin
      r = rand_word();
      pkt = base_packet(32'h0000_1000 + 32'(4 * i));
      pkt.rd    = {1'b0, r[3:0]};
      pkt.wen   = (r[5:4] != 2'b00);
      pkt.wdata = rand_word();
      drive_cycle(pkt);
    end
    for (int i = 0; i < 2; i++) begin
      pkt = base_packet(32'h0000_1100);
      pkt.wen   = 1'b1;
      pkt.wdata = rand_word();
      drive_cycle(pkt);
    end
    for (int i = 0; i < num_gprs; i++) begin
      r = rand_word();
      read_state(5'(i), r[4:0], csr_mstatus);
    end
    report_test("register writes");

    for (int i = 0; i < n_csr_ops; i++) begin
      r = rand_word();
      addr = pick_csr(r[2:0]);
      pkt = base_packet(32'h0000_1200 + 32'(4 * i));
      pkt.csr_op      = csr_op_e'(r[5:4]);
      pkt.csr_addr    = addr;
      pkt.csr_operand = rand_word();
      drive_cycle(pkt);
      read_state(r[12:8], r[20:16], addr);
    end
    report_test("csr operations");

    pkt = base_packet(32'h0000_2000);
    pkt.csr_op      = csr_op_write;
    pkt.csr_addr    = csr_mtvec;
    pkt.csr_operand = 32'h0000_0180;
    drive_cycle(pkt);
    for (int i = 0; i < 2; i++) begin
      pc = (i == 0) ? 32'h0000_2004 : 32'h0000_2102;
      pkt = base_packet(pc);
      pkt.ecall      = (i == 0);
      pkt.misaligned = (i == 1);
      pkt.wen        = 1'b1;
      pkt.rd         = 5'd3;
      pkt.wdata      = rand_word();
      drive_cycle(pkt);
      drive_cycle(wrong_path_packet());
      check_redirect(redirect, make_redirect(1'b1, 1'b0, 32'h0000_0180), "trap redirect");
      read_state(5'd3, 5'd9, csr_mepc);
      check_word(csr_rdata, pc, "mepc after trap");
      read_state(5'd9, 5'd3, csr_mcause);
      check_word(csr_rdata, (i == 0) ? 32'd11 : 32'd0, "mcause after trap");
    end
    report_test("traps");

    for (int i = 0; i < 2; i++) begin
      pkt = base_packet(32'h0000_3000 + 32'(i * 256));
      pkt.next_pc    = 32'h0000_3400 + 32'(i * 256);
      pkt.fence_i    = (i == 0);
      pkt.mispredict = (i == 1);
      drive_cycle(pkt);
      drive_cycle(wrong_path_packet());
      check_redirect(redirect, make_redirect(1'b1, i == 0, pkt.next_pc), "flush redirect");
      read_state(5'd9, 5'd0, csr_mepc);
    end
    report_test("flush and squash");

    // correctly predicted jumps change next_pc without any flush.
    pc = 32'h0000_4000;
    for (int i = 0; i < n_flow; i++) begin
      r = rand_word();
      pkt = base_packet(pc);
      if (r[0]) pkt.next_pc = {r[31:2], 2'b00};
      pkt.wen   = 1'b1;
      pkt.rd    = {1'b0, r[7:4]};
      pkt.wdata = rand_word();
      drive_cycle(pkt);
      if (i > 0) check_redirect(redirect, make_redirect(1'b0, 1'b0, prev_npc), "normal flow");
      prev_npc = pkt.next_pc;
      pc       = pkt.next_pc;
    end
    drive_cycle('0);
    check_redirect(redirect, make_redirect(1'b0, 1'b0, prev_npc), "normal flow");
    report_test("normal flow");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // reset covers the first three rising edges.
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule
